//--- compile.f
+incdir+include
logic/aes_sbox_pkg.sv
logic/sub_bus_if.sv
logic/gf256_inverse.sv
logic/byte_substitution.sv
logic/state_substitution.sv
logic/axil_sbox_regs.sv
logic/sbox_accel_top.sv
verif/tb_sbox_accel.sv

//--- include/aes_sbox_config.svh
/*
 * Build options of the AES SubBytes accelerator
 * S-box output register switch, AXI4-Lite address width and register map
 */
`ifndef AES_SBOX_CONFIG_SVH
`define AES_SBOX_CONFIG_SVH

`define SBOX_OUTPUT_REG  1        // 1 registers each S-box output, 0 leaves it combinational
`define AXIL_ADDR_W      6        // Byte address bits of the register window

`define REG_DATA0        6'h00    // Input state words, RW
`define REG_DATA1        6'h04
`define REG_DATA2        6'h08
`define REG_DATA3        6'h0C
`define REG_CTRL         6'h10    // Bit 0 starts a substitution
`define REG_STATUS       6'h14    // Bit 0 done flag, RO
`define REG_RESULT0      6'h20    // Substituted state words, RO
`define REG_RESULT1      6'h24
`define REG_RESULT2      6'h28
`define REG_RESULT3      6'h2C

`endif

//--- logic/aes_sbox_pkg.sv
/*
 * Shared types of the AES SubBytes accelerator
 * Byte, word and state vectors, AXI response codes,
 * state encodings of the AXI4-Lite write and read channels
 */
package aes_sbox_pkg;

    typedef logic [7:0]   aes_byte_t;    // One state byte
    typedef logic [31:0]  axil_word_t;   // One AXI data word
    typedef logic [127:0] aes_state_t;   // Byte k in bits 8k+7:8k
    typedef logic [1:0]   axil_resp_t;   // AXI response code

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Write channel
    typedef enum logic {
        WR_IDLE,    // Waiting for address and data
        WR_RESP     // bvalid held until bready
    } wr_state_e;

    // Read channel
    typedef enum logic {
        RD_IDLE,    // arready high
        RD_DATA     // rvalid held until rready
    } rd_state_e;

endpackage

//--- logic/axil_sbox_regs.sv
/*
 * AXI4-Lite register block of the SubBytes accelerator
 * Write and read channel FSMs, offset decode, byte-strobed DATA words,
 * CTRL start pulse, STATUS done flag and captured RESULT words
 */
`timescale 1ns/100ps
`include "aes_sbox_config.svh"

module axil_sbox_regs
    import aes_sbox_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    // Write address and data
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  logic [`AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    input  axil_word_t              i_wdata,
    input  logic [3:0]              i_wstrb,
    // Write response
    output logic                    o_bvalid,
    input  logic                    i_bready,
    output axil_resp_t              o_bresp,
    // Read address and data
    input  logic                    i_arvalid,
    output logic                    o_arready,
    input  logic [`AXIL_ADDR_W-1:0] i_araddr,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    output axil_word_t              o_rdata,
    output axil_resp_t              o_rresp,
    // Substitution array
    sub_bus_if.regs                 sub
);

    wr_state_e  wr_state;
    rd_state_e  rd_state;
    logic       wr_hs;          // Address and data accepted this cycle
    logic       rd_hs;          // Read address accepted this cycle
    logic       wr_data_sel;    // Write hits a DATA word
    logic       wr_ctrl_sel;    // Write hits CTRL
    axil_resp_t rd_resp;
    axil_word_t rd_word;
    aes_state_t data_state;     // DATA0..3, word n at bits 32n+31:32n
    aes_state_t result_state;   // RESULT0..3
    logic       done_flag;      // STATUS bit 0
    logic       start_q;

    assign wr_hs = o_awready & i_awvalid & o_wready & i_wvalid;
    assign rd_hs = o_arready & i_arvalid;

    // Write offset decode, anything else is SLVERR
    always_comb
    begin
        wr_data_sel = 1'b0;
        wr_ctrl_sel = 1'b0;
        case (i_awaddr)
            `REG_DATA0, `REG_DATA1, `REG_DATA2, `REG_DATA3: wr_data_sel = 1'b1;
            `REG_CTRL:                                      wr_ctrl_sel = 1'b1;
            default:                                        wr_data_sel = 1'b0;
        endcase
    end

    // Write channel FSM, ready is a one-cycle pulse after both valids
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            wr_state  <= WR_IDLE;
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_bresp   <= RESP_OKAY;
        end
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    o_awready <= i_awvalid & i_wvalid & ~o_awready;
                    o_wready  <= i_awvalid & i_wvalid & ~o_wready;
                    if (wr_hs)
                    begin
                        o_bvalid <= 1'b1;
                        o_bresp  <= (wr_data_sel | wr_ctrl_sel) ? RESP_OKAY : RESP_SLVERR;
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP:
                begin
                    if (i_bready)
                    begin
                        o_bvalid <= 1'b0;   // Response taken
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // DATA words, per-byte strobes
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
            data_state <= '0;
        else if (wr_hs && wr_data_sel)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (i_wstrb[b])
                    data_state[{i_awaddr[3:2], 5'd0} + 8*b +: 8] <= i_wdata[8*b +: 8];
            end
        end
    end

    // Start pulse one cycle after the CTRL handshake
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
            start_q <= 1'b0;
        else
            start_q <= wr_hs & wr_ctrl_sel & i_wdata[0];
    end

    assign sub.start    = start_q;
    assign sub.state_in = data_state;   // Stable, no write completes during start

    // Result capture and done flag
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            result_state <= '0;
            done_flag    <= 1'b0;
        end
        else if (sub.done)
        begin
            result_state <= sub.state_out;
            done_flag    <= 1'b1;    // Wins over a start in the same cycle
        end
        else if (sub.start)
            done_flag <= 1'b0;
    end

    // Read offset decode and mux
    always_comb
    begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (i_araddr)
            `REG_DATA0, `REG_DATA1, `REG_DATA2, `REG_DATA3:
                rd_word = data_state[{i_araddr[3:2], 5'd0} +: 32];
            `REG_RESULT0, `REG_RESULT1, `REG_RESULT2, `REG_RESULT3:
                rd_word = result_state[{i_araddr[3:2], 5'd0} +: 32];
            `REG_STATUS: rd_word = {31'd0, done_flag};
            `REG_CTRL:   rd_word = '0;           // Start bit self-clears
            default:     rd_resp = RESP_SLVERR;  // Unmapped, zero data
        endcase
    end

    assign o_arready = (rd_state == RD_IDLE);

    // Read channel FSM, rdata frozen while rvalid waits
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            rd_state <= RD_IDLE;
            o_rvalid <= 1'b0;
            o_rdata  <= '0;
            o_rresp  <= RESP_OKAY;
        end
        else
        begin
            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_hs)
                    begin
                        o_rvalid <= 1'b1;
                        o_rdata  <= rd_word;
                        o_rresp  <= rd_resp;
                        rd_state <= RD_DATA;
                    end
                end
                RD_DATA:
                begin
                    if (i_rready)
                    begin
                        o_rvalid <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

endmodule

//--- logic/byte_substitution.sv
/*
 * AES S-box for one byte
 * Field inverse followed by the affine map and the 0x63 constant,
 * output registered on i_valid or combinational per build option
 */
`timescale 1ns/100ps
`include "aes_sbox_config.svh"

module byte_substitution
    import aes_sbox_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_valid,     // Loads the output register
    input  aes_byte_t i_byte,
    output aes_byte_t o_byte
);

    localparam aes_byte_t AFFINE_ROW = 8'h1F;   // Column pattern of input bit 0
    localparam aes_byte_t AFFINE_ADD = 8'h63;

    aes_byte_t inv_byte;     // Multiplicative inverse
    aes_byte_t affine_sum;   // Matrix product, before the constant
    aes_byte_t sub_byte;     // Finished S-box value

    gf256_inverse u_inverse (
        .i_byte    (i_byte),
        .o_inverse (inv_byte)
    );

    // Input bit k selects 0x1F rotated left by k
    always_comb
    begin
        affine_sum = '0;
        for (int k = 0; k < 8; k++)
        begin
            affine_sum = affine_sum ^
                ({8{inv_byte[k]}} & aes_byte_t'((AFFINE_ROW << k) | (AFFINE_ROW >> (8 - k))));
        end
    end

    assign sub_byte = affine_sum ^ AFFINE_ADD;

    if (`SBOX_OUTPUT_REG == 1)
    begin : g_out_reg
        always_ff @(posedge i_clock)
        begin
            if (i_valid)
                o_byte <= sub_byte;    // Held until the next valid
        end
    end
    else
    begin : g_out_comb
        assign o_byte = sub_byte;
    end

endmodule

//--- logic/gf256_inverse.sv
/*
 * Multiplicative inverse in GF(2^8), AES polynomial 0x11B
 * Computed as x^254 through a fixed chain of squarings and products
 * Purely combinational, zero maps to zero
 */
`timescale 1ns/100ps

module gf256_inverse
    import aes_sbox_pkg::*;
(
    input  aes_byte_t i_byte,       // Field element
    output aes_byte_t o_inverse     // Its inverse, 0 for 0
);

    aes_byte_t pw_2, pw_3, pw_6, pw_12, pw_15;
    aes_byte_t pw_30, pw_60, pw_120, pw_240, pw_252;

    // Shift-and-add product, reducing by 0x1B on every carry out
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            acc = acc ^ ({8{b[i]}} & sh);                      // Partial product
            sh  = {sh[6:0], 1'b0} ^ ({8{sh[7]}} & 8'h1B);      // xtime
        end
        return acc;
    endfunction

    // Squaring is linear over GF(2)
    // Bits 4..7 land on x^8..x^14 and fold back through the polynomial
    function automatic aes_byte_t gf_sq(input aes_byte_t a);
        aes_byte_t s;
        s[0] = a[0] ^ a[4] ^ a[6];
        s[1] = a[4] ^ a[6] ^ a[7];
        s[2] = a[1] ^ a[5];
        s[3] = a[4] ^ a[5] ^ a[6] ^ a[7];
        s[4] = a[2] ^ a[4] ^ a[7];
        s[5] = a[5] ^ a[6];
        s[6] = a[3] ^ a[5];
        s[7] = a[6] ^ a[7];
        return s;
    endfunction

    // Exponent chain up to 254
    assign pw_2   = gf_sq(i_byte);
    assign pw_3   = gf_mul(pw_2, i_byte);
    assign pw_6   = gf_sq(pw_3);
    assign pw_12  = gf_sq(pw_6);
    assign pw_15  = gf_mul(pw_12, pw_3);
    assign pw_30  = gf_sq(pw_15);
    assign pw_60  = gf_sq(pw_30);
    assign pw_120 = gf_sq(pw_60);
    assign pw_240 = gf_sq(pw_120);
    assign pw_252 = gf_mul(pw_240, pw_12);       // 240 + 12

    assign o_inverse = gf_mul(pw_252, pw_2);     // 252 + 2, x^-1 for x != 0

endmodule

//--- logic/sbox_accel_top.sv
/*
 * AES SubBytes accelerator top level
 * AXI4-Lite slave ports, register block and 16-byte substitution array
 */
`timescale 1ns/100ps
`include "aes_sbox_config.svh"

module sbox_accel_top
    import aes_sbox_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    i_rst_n,     // Synchronous, active low
    // Write address and data
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  logic [`AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    input  axil_word_t              i_wdata,
    input  logic [3:0]              i_wstrb,
    // Write response
    output logic                    o_bvalid,
    input  logic                    i_bready,
    output axil_resp_t              o_bresp,
    // Read address
    input  logic                    i_arvalid,
    output logic                    o_arready,
    input  logic [`AXIL_ADDR_W-1:0] i_araddr,
    // Read data
    output logic                    o_rvalid,
    input  logic                    i_rready,
    output axil_word_t              o_rdata,
    output axil_resp_t              o_rresp
);

    sub_bus_if sub_bus ();   // Start/state to the array, result/done back

    axil_sbox_regs u_regs (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .sub       (sub_bus.regs)
    );

    // No stall input, runs regardless of AXI back-pressure
    state_substitution u_array (
        .i_clock (i_clock),
        .sub     (sub_bus.array)
    );

endmodule

//--- logic/state_substitution.sv
/*
 * SubBytes over the full 128-bit state
 * Sixteen parallel S-boxes, done pulse aligned
 * with the optional S-box output register
 */
`timescale 1ns/100ps
`include "aes_sbox_config.svh"

module state_substitution
    import aes_sbox_pkg::*;
(
    input  logic     i_clock,
    sub_bus_if.array sub         // Start and state in, result and done out
);

    aes_state_t sub_bytes;   // Gathered S-box outputs

    for (genvar k = 0; k < 16; k++)
    begin : g_byte
        byte_substitution u_sbox (
            .i_clock (i_clock),
            .i_valid (sub.start),                 // Every byte loads on start
            .i_byte  (sub.state_in[8*k +: 8]),
            .o_byte  (sub_bytes[8*k +: 8])
        );
    end

    assign sub.state_out = sub_bytes;

    // Done tracks the S-box latency
    if (`SBOX_OUTPUT_REG == 1)
    begin : g_done_reg
        logic done_q;

        always_ff @(posedge i_clock)
        begin
            done_q <= sub.start;   // One stage, same as the byte registers
        end

        assign sub.done = done_q;
    end
    else
    begin : g_done_comb
        assign sub.done = sub.start;   // Result ready in the start cycle
    end

endmodule

//--- logic/sub_bus_if.sv
/*
 * Link between the register block and the substitution array
 * Start pulse with the input state, done pulse with the result
 */
`timescale 1ns/100ps

interface sub_bus_if
    import aes_sbox_pkg::*;
();

    logic       start;       // One cycle, state_in stable with it
    aes_state_t state_in;    // State to substitute
    aes_state_t state_out;   // Valid while done is high
    logic       done;        // One cycle

    // Register block side
    modport regs (
        output start,
        output state_in,
        input  state_out,
        input  done
    );

    // Substitution array side
    modport array (
        input  start,
        input  state_in,
        output state_out,
        output done
    );

endinterface

//--- run_sim.sh
#!/bin/sh
# Build and run the SubBytes accelerator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_sbox_accel \
    -f compile.f \
    -o tb_sbox_accel

./obj_dir/tb_sbox_accel > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- verif/tb_sbox_accel.sv
/*
 * Testbench of the AES SubBytes accelerator
 * AXI4-Lite master tasks, reference S-box by exhaustive inverse search,
 * result comparator process, cycle-count timeout
 */
`timescale 1ns/100ps
`include "aes_sbox_config.svh"

module tb_sbox_accel
    import aes_sbox_pkg::*;
();

    localparam int MAX_CYCLES = 20000;   // ~40 transactions x 10 cycles x 30 runs, plus margin

    logic                    i_clock;
    logic                    i_rst_n;
    logic                    i_awvalid;
    logic                    o_awready;
    logic [`AXIL_ADDR_W-1:0] i_awaddr;
    logic                    i_wvalid;
    logic                    o_wready;
    axil_word_t              i_wdata;
    logic [3:0]              i_wstrb;
    logic                    o_bvalid;
    logic                    i_bready;
    axil_resp_t              o_bresp;
    logic                    i_arvalid;
    logic                    o_arready;
    logic [`AXIL_ADDR_W-1:0] i_araddr;
    logic                    o_rvalid;
    logic                    i_rready;
    axil_word_t              o_rdata;
    axil_resp_t              o_rresp;

    axil_word_t exp_q[$];    // Expected RESULT words
    axil_word_t got_q[$];    // RESULT words as read
    axil_word_t cmp_exp;
    axil_word_t cmp_got;
    aes_state_t model;       // DATA contents the DUT should hold
    aes_state_t st;
    axil_word_t word;
    axil_resp_t resp;
    integer     seed;
    int         errors, checks, tests, cycles, test_err;
    aes_byte_t  known_in[6]  = '{8'h00, 8'h01, 8'h53, 8'h10, 8'hFF, 8'h80};
    aes_byte_t  known_out[6] = '{8'h63, 8'h7C, 8'hED, 8'hCA, 8'h16, 8'hCD};   // FIPS-197 table

    sbox_accel_top dut0 (.*);

    always #2 i_clock = ~i_clock;   // 4 ns period

    // Carry-less product, then long division by 0x11B
    function automatic aes_byte_t gf_product(input aes_byte_t a, input aes_byte_t b);
        logic [14:0] p;
        p = '0;
        for (int i = 0; i < 8; i++)
            if (b[i])
                p = p ^ (15'(a) << i);
        for (int i = 14; i >= 8; i--)
            if (p[i])
                p = p ^ (15'h11B << (i - 8));
        return p[7:0];
    endfunction

    // Inverse by search, then bitwise affine map
    function automatic aes_byte_t sbox_ref(input aes_byte_t x);
        aes_byte_t inv;
        aes_byte_t s;
        inv = '0;                          // 0 has no inverse, stays 0
        for (int y = 1; y < 256; y++)
            if (gf_product(x, aes_byte_t'(y)) == 8'h01)
                inv = aes_byte_t'(y);
        for (int i = 0; i < 8; i++)
            s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                 ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        return s ^ 8'h63;
    endfunction

    function automatic axil_word_t expected_word(input aes_state_t s, input int n);
        axil_word_t w;
        for (int b = 0; b < 4; b++)
            w[8*b +: 8] = sbox_ref(s[32*n + 8*b +: 8]);
        return w;
    endfunction

    // Called at a falling edge, returns at a falling edge
    task automatic write_register(input logic [5:0] addr, input axil_word_t data,
                                  input logic [3:0] strb, input int stall,
                                  output axil_resp_t bresp);
        i_awvalid = 1'b1;
        i_awaddr  = addr;
        i_wvalid  = 1'b1;
        i_wdata   = data;
        i_wstrb   = strb;
        @(negedge i_clock);
        while (!(o_awready && o_wready))
            @(negedge i_clock);
        @(negedge i_clock);                // Handshake on the edge just passed
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        while (!o_bvalid)
            @(negedge i_clock);
        bresp = o_bresp;
        for (int i = 0; i < stall; i++)
        begin
            @(negedge i_clock);            // bready held low
            if (!o_bvalid || o_bresp !== bresp)
            begin
                errors++;
                $display("Write response to %h dropped or changed under back-pressure at %0t ns",
                         addr, $time);
            end
        end
        i_bready = 1'b1;
        @(negedge i_clock);
        i_bready = 1'b0;
    endtask

    task automatic read_register(input logic [5:0] addr, input int stall,
                                 output axil_word_t data, output axil_resp_t rresp);
        i_arvalid = 1'b1;
        i_araddr  = addr;
        while (!o_arready)
            @(negedge i_clock);
        @(negedge i_clock);
        i_arvalid = 1'b0;
        while (!o_rvalid)
            @(negedge i_clock);
        data  = o_rdata;
        rresp = o_rresp;
        for (int i = 0; i < stall; i++)
        begin
            @(negedge i_clock);            // rready held low
            if (!o_rvalid || o_rdata !== data || o_rresp !== rresp)
            begin
                errors++;
                $display("Read data of %h dropped or changed under back-pressure at %0t ns",
                         addr, $time);
            end
        end
        i_rready = 1'b1;
        @(negedge i_clock);
        i_rready = 1'b0;
    endtask

    // Four DATA writes, model merged per strobe bit
    task automatic load_state(input aes_state_t s, input logic [15:0] strbs, input int stall);
        axil_resp_t r;
        for (int n = 0; n < 4; n++)
        begin
            write_register(6'(4*n), s[32*n +: 32], strbs[4*n +: 4], stall, r);
            for (int b = 0; b < 4; b++)
                if (strbs[4*n + b])
                    model[32*n + 8*b +: 8] = s[32*n + 8*b +: 8];
            checks++;
            if (r !== RESP_OKAY)
            begin
                errors++;
                $display("ERROR at %0t ns: DATA%0d write response %b", $time, n, r);
            end
        end
    endtask

    task automatic start_and_wait(input int stall);
        axil_word_t w;
        axil_resp_t r;
        int         polls;
        write_register(`REG_CTRL, 32'h1, 4'hF, stall, r);
        polls = 0;
        w = '0;
        while (w[0] !== 1'b1 && polls < 8)
        begin
            read_register(`REG_STATUS, stall, w, r);
            polls++;
            // Registered S-box: first poll lands before done
            if (`SBOX_OUTPUT_REG == 1 && stall == 0 && polls == 1 && w[0] !== 1'b0)
            begin
                errors++;
                $display("ERROR at %0t ns: STATUS reads %h right after CTRL write, expected 0",
                         $time, w);
            end
        end
        checks++;
        if (w[0] !== 1'b1)
        begin
            errors++;
            $display("Done flag never set within %0d STATUS polls at %0t ns", polls, $time);
        end
    endtask

    task automatic check_result(input int stall);
        axil_word_t w;
        axil_resp_t r;
        for (int n = 0; n < 4; n++)
        begin
            exp_q.push_back(expected_word(model, n));
            read_register(`REG_RESULT0 + 6'(4*n), stall, w, r);
            got_q.push_back(w);            // Compared by the checker process
            if (r !== RESP_OKAY)
            begin
                errors++;
                $display("ERROR at %0t ns: RESULT%0d read response %b", $time, n, r);
            end
        end
    endtask

    task automatic run_case(input aes_state_t s, input logic [15:0] strbs, input int stall);
        load_state(s, strbs, stall);
        start_and_wait(stall);
        check_result(stall);
    endtask

    task automatic end_test(input string name);
        while (got_q.size() > 0)
            @(negedge i_clock);            // Let the checker drain
        tests++;
        $display("Test %s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // Result checker
    always @(posedge i_clock)
    begin
        if (got_q.size() > 0 && exp_q.size() > 0)
        begin
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            checks++;
            if (cmp_got !== cmp_exp)
            begin
                errors++;
                $display("ERROR at %0t ns: RESULT word %h, expected %h",
                         $time, cmp_got, cmp_exp);
            end
        end
    end

    // Timeout
    always @(posedge i_clock)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout, run still busy after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial
    begin
        seed      = 32'h5415_7de5;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cycles    = 0;
        test_err  = 0;
        model     = '0;
        i_clock   = 1'b0;
        i_rst_n   = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_bready  = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_rready  = 1'b0;
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_rst_n = 1'b1;

        // Handshake outputs out of reset
        checks++;
        if (o_awready !== 1'b0 || o_wready !== 1'b0 || o_bvalid !== 1'b0 ||
            o_rvalid !== 1'b0 || o_arready !== 1'b1)
        begin
            errors++;
            $display("ERROR at %0t ns: aw/w/b/r/ar ready-valid %b%b%b%b%b, expected 00001",
                     $time, o_awready, o_wready, o_bvalid, o_rvalid, o_arready);
        end

        // Reset values of STATUS and RESULT
        read_register(`REG_STATUS, 0, word, resp);
        checks++;
        if (word !== '0)
        begin
            errors++;
            $display("ERROR at %0t ns: STATUS after reset %h, expected 0", $time, word);
        end
        for (int n = 0; n < 4; n++)
        begin
            read_register(`REG_RESULT0 + 6'(4*n), 0, word, resp);
            checks++;
            if (word !== '0 || resp !== RESP_OKAY)
            begin
                errors++;
                $display("ERROR at %0t ns: RESULT%0d before first start %h / %b, expected 0",
                         $time, n, word, resp);
            end
        end
        end_test("done_flag");

        for (int i = 0; i < 6; i++)
        begin
            checks++;
            if (sbox_ref(known_in[i]) !== known_out[i])
            begin
                errors++;
                $display("ERROR at %0t ns: reference S-box of %h gives %h, expected %h",
                         $time, known_in[i], sbox_ref(known_in[i]), known_out[i]);
            end
        end
        for (int k = 0; k < 16; k++)
            st[8*k +: 8] = known_in[k % 6];
        run_case(st, 16'hFFFF, 0);
        end_test("known");

        for (int r = 0; r < 16; r++)
        begin
            for (int k = 0; k < 16; k++)
                st[8*k +: 8] = 8'(16*r + k);
            run_case(st, 16'hFFFF, 0);
        end
        end_test("exhaustive");

        for (int r = 0; r < 10; r++)
        begin
            st = {$random(seed), $random(seed), $random(seed), $random(seed)};
            run_case(st, 16'($random(seed)), 0);
        end
        end_test("random");

        // Read-only and unmapped offsets
        write_register(`REG_STATUS, 32'h0, 4'hF, 0, resp);
        checks++;
        if (resp !== RESP_SLVERR)
        begin
            errors++;
            $display("ERROR at %0t ns: STATUS write response %b, expected SLVERR", $time, resp);
        end
        read_register(`REG_STATUS, 0, word, resp);
        checks++;
        if (word !== 32'h1)
        begin
            errors++;
            $display("ERROR at %0t ns: STATUS changed by write, reads %h", $time, word);
        end
        write_register(`REG_RESULT1, 32'hFFFF_FFFF, 4'hF, 0, resp);
        checks++;
        if (resp !== RESP_SLVERR)
        begin
            errors++;
            $display("ERROR at %0t ns: RESULT1 write response %b, expected SLVERR", $time, resp);
        end
        check_result(0);                   // Still the last substitution
        read_register(6'h18, 0, word, resp);
        checks++;
        if (resp !== RESP_SLVERR || word !== '0)
        begin
            errors++;
            $display("ERROR at %0t ns: read of 0x18 gives %h / %b, expected 0 / SLVERR",
                     $time, word, resp);
        end
        read_register(`REG_DATA0, 0, word, resp);
        checks++;
        if (word !== model[31:0])
        begin
            errors++;
            $display("ERROR at %0t ns: DATA0 %h, expected %h", $time, word, model[31:0]);
        end
        for (int r = 0; r < 4; r++)
        begin
            st = {$random(seed), $random(seed), $random(seed), $random(seed)};
            run_case(st, 16'hFFFF, int'($random(seed) & 32'h7) + 1);
        end
        end_test("errors_bp");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
